// File: common/vid_pkg.sv
`default_nettype none

package vid_pkg;

    // Frame geometry
    localparam int IMG_COLS = 8;
    localparam int IMG_ROWS = 6;

    // Counter widths follow the frame size
    localparam int COL_W = $clog2(IMG_COLS);
    localparam int ROW_W = $clog2(IMG_ROWS);

    typedef logic [7:0]       pix_t;
    typedef logic [COL_W-1:0] col_t;
    typedef logic [ROW_W-1:0] row_t;

    // One pixel of the stream with its framing levels
    typedef struct packed {
        logic fsync;
        logic rsync;
        pix_t data;
    } vid_beat_t;

    // Three vertically aligned pixels, bot is the newest row
    typedef struct packed {
        logic fsync;
        logic rsync;
        pix_t top;
        pix_t mid;
        pix_t bot;
    } tap_beat_t;

    // 3x3 neighbourhood in raster order, p1 top-left and p9 bottom-right
    typedef struct packed {
        logic fsync;
        logic rsync;
        pix_t p1;
        pix_t p2;
        pix_t p3;
        pix_t p4;
        pix_t p5;
        pix_t p6;
        pix_t p7;
        pix_t p8;
        pix_t p9;
    } win_beat_t;

endpackage

`default_nettype wire

// File: line_buffer/line_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module line_buffer
    import vid_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  vid_beat_t vid_in,
    output tap_beat_t taps
);

    col_t       wcol;
    col_t       wcol_d;
    logic [1:0] rows_seen;
    logic       row_end;
    vid_beat_t  in_d;
    vid_beat_t  in_q;
    pix_t       mid_d;
    pix_t       mid_q;
    pix_t       top_d;
    // Bit 0 marks a valid mid tap, bit 1 a valid top tap
    logic [1:0] ok_d;
    logic [1:0] ok_q;

    // Falling row sync closes a row
    assign row_end = in_d.rsync & ~vid_in.rsync;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wcol      <= '0;
            rows_seen <= '0;
        end else begin
            wcol <= vid_in.rsync ? wcol + col_t'(1) : '0;
            if (!vid_in.fsync) begin
                rows_seen <= '0;
            end else if (row_end && rows_seen != 2'd2) begin
                rows_seen <= rows_seen + 2'd1;
            end
        end
    end

    // Two-cycle alignment pipeline, the second memory reads one cycle after the first
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_d   <= '0;
            in_q   <= '0;
            wcol_d <= '0;
            ok_d   <= '0;
            ok_q   <= '0;
        end else begin
            in_d   <= vid_in;
            in_q   <= in_d;
            wcol_d <= wcol;
            ok_d   <= {rows_seen == 2'd2, rows_seen != 2'd0};
            ok_q   <= ok_d;
        end
    end

    always_ff @(posedge clk) begin
        mid_q <= mid_d;
    end

    // Holds the incoming row, reads back the previous one
    row_ram i_ram_prev (
        .clk   (clk),
        .we    (vid_in.rsync),
        .addr  (wcol),
        .wdata (vid_in.data),
        .rdata (mid_d)
    );

    // Holds the previous row, reads back the one before it
    row_ram i_ram_prev2 (
        .clk   (clk),
        .we    (in_d.rsync),
        .addr  (wcol_d),
        .wdata (mid_d),
        .rdata (top_d)
    );

    // Rows above the frame start read as zero, stale memory never leaks out
    always_comb begin
        taps.fsync = in_q.fsync;
        taps.rsync = in_q.rsync;
        taps.bot   = in_q.data;
        taps.mid   = ok_q[0] ? mid_q : '0;
        taps.top   = ok_q[1] ? top_d : '0;
    end

endmodule

`default_nettype wire

// File: line_buffer/row_ram.sv
`timescale 1ns/10ps
`default_nettype none

module row_ram
    import vid_pkg::*;
(
    input  logic clk,
    input  logic we,
    input  col_t addr,
    input  pix_t wdata,
    output pix_t rdata
);

    // One pixel per column of a row
    pix_t mem [IMG_COLS];

    // Old contents come out while the new pixel goes in, so a row appears one row later
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the edge detector testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f src.f --top-module tb_edge_detect -o sim_edge
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_edge > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

echo "Simulation passed"
exit 0

// File: src.f
common/vid_pkg.sv
line_buffer/row_ram.sv
line_buffer/line_buffer.sv
window/window_cache.sv
src/sobel_filter.sv
src/edge_detect_top.sv
verif/tb_edge_detect.sv

// File: src/edge_detect_top.sv
`timescale 1ns/10ps
`default_nettype none

module edge_detect_top
    import vid_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  vid_beat_t vid_in,
    output vid_beat_t vid_out
);

    tap_beat_t taps;
    win_beat_t win;

    // Row delay lines, three vertical taps
    line_buffer i_line_buffer (
        .clk    (clk),
        .rst_n  (rst_n),
        .vid_in (vid_in),
        .taps   (taps)
    );

    // 3x3 neighbourhood with zero padding at the borders
    window_cache i_window_cache (
        .clk   (clk),
        .rst_n (rst_n),
        .taps  (taps),
        .win   (win)
    );

    // Gradient magnitude, two pipeline stages
    sobel_filter i_sobel_filter (
        .clk     (clk),
        .rst_n   (rst_n),
        .win     (win),
        .vid_out (vid_out)
    );

endmodule

`default_nettype wire

// File: src/sobel_filter.sv
`timescale 1ns/10ps
`default_nettype none

module sobel_filter
    import vid_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  win_beat_t win,
    output vid_beat_t vid_out
);

    // Holds +/-1020, the largest kernel response
    typedef logic signed [10:0] grad_t;

    grad_t       gx_q;
    grad_t       gy_q;
    logic        fsync_s1;
    logic        rsync_s1;
    logic [10:0] mag_sum;
    pix_t        mag_clip;

    // Weighted column or row sum a + 2b + c
    function automatic grad_t weigh(input pix_t a, input pix_t b, input pix_t c);
        return grad_t'({3'b000, a}) + grad_t'({2'b00, b, 1'b0}) + grad_t'({3'b000, c});
    endfunction

    function automatic logic [9:0] magnitude(input grad_t g);
        grad_t neg;
        neg = -g;
        return g[10] ? neg[9:0] : g[9:0];
    endfunction

    // Stage 1, signed gradients
    always_ff @(posedge clk) begin
        gx_q <= weigh(win.p3, win.p6, win.p9) - weigh(win.p1, win.p4, win.p7);
        gy_q <= weigh(win.p7, win.p8, win.p9) - weigh(win.p1, win.p2, win.p3);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fsync_s1 <= 1'b0;
            rsync_s1 <= 1'b0;
        end else begin
            fsync_s1 <= win.fsync;
            rsync_s1 <= win.rsync;
        end
    end

    // |Gx| + |Gy| tops out at 2040, clipped to the pixel range
    always_comb begin
        mag_sum  = {1'b0, magnitude(gx_q)} + {1'b0, magnitude(gy_q)};
        mag_clip = (mag_sum > 11'd255) ? '1 : mag_sum[7:0];
    end

    // Stage 2, output beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vid_out <= '0;
        end else begin
            vid_out.fsync <= fsync_s1;
            vid_out.rsync <= rsync_s1;
            vid_out.data  <= mag_clip;
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_edge_detect.sv
`timescale 1ns/10ps
`default_nettype none

module tb_edge_detect
    import vid_pkg::*;
;

    typedef enum int {img_const, img_hramp, img_vstep, img_random} img_kind_t;

    // Spot is the hand-derived output at centre (2,3), -1 where it is not known
    typedef struct packed {
        img_kind_t kind;
        int        param;
        int        gap;
        int        frames;
        int        spot;
    } scen_t;

    localparam int N_SCEN      = 5;
    localparam int DRAIN_LIMIT = 200;

    scen_t scen_tab [N_SCEN] = '{
        '{img_const,  100, 2, 1, 0},
        '{img_hramp,  20,  2, 1, 160},
        '{img_vstep,  200, 3, 1, 255},
        '{img_random, 0,   2, 3, -1},
        '{img_random, 0,   5, 2, -1}
    };

    logic      clk = 1'b0;
    logic      rst_n;
    vid_beat_t vid_in;
    vid_beat_t vid_out;

    int   seed = 50654;
    int   spot = -1;
    int   out_row = 0;
    int   out_col = 0;
    int   frames_sent = 0;
    int   frames_done = 0;
    logic prev_rsync = 1'b0;
    logic prev_fsync = 1'b0;
    pix_t frame_img [IMG_ROWS][IMG_COLS];
    pix_t exp_q [$];

    edge_detect_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .vid_in  (vid_in),
        .vid_out (vid_out)
    );

    always #4 clk = ~clk;

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_pix(input string name, input pix_t got, input pix_t expected);
        if (got !== expected) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, expected);
            stop_run();
        end
    endtask

    task automatic check_row(input string name, input row_t got, input row_t expected);
        if (got !== expected) begin
            $display("FAIL %s got 0x%h expected 0x%h", name, got, expected);
            stop_run();
        end
    endtask

    // Zero padding outside the image
    function automatic int pixel_at(input int r, input int c);
        if (r < 0 || r >= IMG_ROWS || c < 0 || c >= IMG_COLS) begin
            return 0;
        end
        return int'(frame_img[r][c]);
    endfunction

    // Sobel reference, centres on rows 0 to IMG_ROWS-2
    task automatic build_expected();
        int gx;
        int gy;
        int mag;
        for (int r = 0; r < IMG_ROWS - 1; r++) begin
            for (int c = 0; c < IMG_COLS; c++) begin
                gx = pixel_at(r - 1, c + 1) + 2 * pixel_at(r, c + 1) + pixel_at(r + 1, c + 1)
                   - pixel_at(r - 1, c - 1) - 2 * pixel_at(r, c - 1) - pixel_at(r + 1, c - 1);
                gy = pixel_at(r + 1, c - 1) + 2 * pixel_at(r + 1, c) + pixel_at(r + 1, c + 1)
                   - pixel_at(r - 1, c - 1) - 2 * pixel_at(r - 1, c) - pixel_at(r - 1, c + 1);
                mag = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
                exp_q.push_back(mag > 255 ? 8'hff : pix_t'(mag));
            end
        end
    endtask

    task automatic drive_beat(input logic fsync, input logic rsync, input pix_t data);
        @(posedge clk);
        #1;
        vid_in.fsync = fsync;
        vid_in.rsync = rsync;
        vid_in.data  = data;
    endtask

    task automatic drive_frame(input scen_t s);
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = 0; c < IMG_COLS; c++) begin
                case (s.kind)
                    img_const:  frame_img[r][c] = pix_t'(s.param);
                    img_hramp:  frame_img[r][c] = pix_t'(s.param * c);
                    img_vstep:  frame_img[r][c] = (r >= IMG_ROWS / 2) ? pix_t'(s.param) : '0;
                    default:    frame_img[r][c] = pix_t'($random(seed));
                endcase
            end
        end
        build_expected();
        // Frame sync opens a little ahead of the first row
        drive_beat(1'b1, 1'b0, '0);
        drive_beat(1'b1, 1'b0, '0);
        for (int r = 0; r < IMG_ROWS; r++) begin
            for (int c = 0; c < IMG_COLS; c++) begin
                drive_beat(1'b1, 1'b1, frame_img[r][c]);
            end
            repeat (s.gap) drive_beat(1'b1, 1'b0, '0);
        end
        repeat (4) drive_beat(1'b0, 1'b0, '0);
    endtask

    // Outputs settle after the rising edge, so they are read on the falling one
    always @(negedge clk) begin
        if (rst_n) begin
            if (vid_out.rsync) begin
                if (exp_q.size() == 0) begin
                    $display("Output pixel arrived with no expected value queued");
                    stop_run();
                end
                check_pix("vid_out.data", vid_out.data, exp_q.pop_front());
                if (spot >= 0 && out_row == 2 && out_col == 3) begin
                    check_pix("vid_out.data at centre (2,3)", vid_out.data, pix_t'(spot));
                end
                out_col++;
            end else if (prev_rsync) begin
                out_row++;
                out_col = 0;
            end
            if (prev_fsync && !vid_out.fsync) begin
                check_row("output rows per frame", row_t'(out_row), row_t'(IMG_ROWS - 1));
                out_row = 0;
                frames_done++;
            end
            prev_rsync = vid_out.rsync;
            prev_fsync = vid_out.fsync;
        end
    end

    initial begin
        vid_in = '0;
        rst_n  = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < N_SCEN; i++) begin
            spot = scen_tab[i].spot;
            for (int f = 0; f < scen_tab[i].frames; f++) begin
                drive_frame(scen_tab[i]);
                frames_sent++;
            end
        end
        for (int n = 0; n < DRAIN_LIMIT && (exp_q.size() != 0 || frames_done != frames_sent);
             n++) begin
            @(posedge clk);
        end
        if (exp_q.size() != 0 || frames_done != frames_sent) begin
            $display("Timed out waiting for the output stream to finish its frames");
            stop_run();
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: window/window_cache.sv
`timescale 1ns/10ps
`default_nettype none

module window_cache
    import vid_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  tap_beat_t taps,
    output win_beat_t win
);

    typedef enum logic [1:0] {
        st_idle,
        st_first_row,
        st_row,
        st_tail
    } cache_state_t;

    // One column of the neighbourhood
    typedef struct packed {
        pix_t top;
        pix_t mid;
        pix_t bot;
    } win_col_t;

    cache_state_t state;
    col_t         tcol;
    col_t         ccol;
    row_t         row_cnt;
    logic         last_col;
    logic         row_done;
    logic         left_zero;
    logic         right_zero;
    // Entry 0 is the centre column, entry 1 the left column
    win_col_t     col_q [2];

    assign last_col = tcol == col_t'(IMG_COLS - 1);
    assign row_done = (state == st_first_row && taps.rsync && last_col) || state == st_tail;

    // Live tap is the right column, so the centre trails the tap by one column
    assign ccol       = (state == st_tail) ? col_t'(IMG_COLS - 1) : tcol - col_t'(1);
    assign left_zero  = ccol == '0;
    assign right_zero = ccol == col_t'(IMG_COLS - 1);

    always_ff @(posedge clk) begin
        if (taps.rsync) begin
            col_q[1] <= col_q[0];
            col_q[0] <= {taps.top, taps.mid, taps.bot};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tcol    <= '0;
            row_cnt <= '0;
        end else begin
            tcol <= taps.rsync ? tcol + col_t'(1) : '0;
            if (!taps.fsync) begin
                row_cnt <= '0;
            end else if (row_done && row_cnt != row_t'(IMG_ROWS - 1)) begin
                row_cnt <= row_cnt + row_t'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    // The first input row only fills the cache
                    if (taps.fsync && taps.rsync) begin
                        state <= (row_cnt == '0) ? st_first_row : st_row;
                    end
                end
                st_first_row: begin
                    if (taps.rsync && last_col) begin
                        state <= st_idle;
                    end
                end
                st_row: begin
                    if (taps.rsync && last_col) begin
                        state <= st_tail;
                    end
                end
                st_tail: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Tail cycle emits the right-edge window after the row has ended
    always_comb begin
        win.fsync = taps.fsync | (state == st_tail);
        win.rsync = (state == st_row && taps.rsync) || state == st_tail;
        win.p1    = left_zero ? '0 : col_q[1].top;
        win.p2    = col_q[0].top;
        win.p3    = right_zero ? '0 : taps.top;
        win.p4    = left_zero ? '0 : col_q[1].mid;
        win.p5    = col_q[0].mid;
        win.p6    = right_zero ? '0 : taps.mid;
        win.p7    = left_zero ? '0 : col_q[1].bot;
        win.p8    = col_q[0].bot;
        win.p9    = right_zero ? '0 : taps.bot;
    end

endmodule

`default_nettype wire
